/* verif/cpu_testdata.hex */
// 32-bit words: program from 0x00, load data at 0x60, expected write count at 0xBF
// From 0xC0 on: expected write pairs, byte address then data
@00
00000001 00000280  // 000 MovRC r0, stack base 0x280
00000201 12345678  // 008 MovRC r2
00020303           // 010 MovRR r3, r2
00030006 00000200  // 014 MovdCR [0x200], r3
00000402 00000180  // 01C MovRdC r4, [0x180]
00000501 00000184  // 024 MovRC r5, 0x184
00050605           // 02C MovRdR r6, [r5]
00050704 00000004  // 030 MovRdRo r7, [r5 + 4]
04000507 00000080  // 038 MovdRoR [r5 + 0x80], r4
00060006 00000208  // 040 MovdCR [0x208], r6
00070006 0000020C  // 048 MovdCR [0x20C], r7
00000801 FFFFFFF0  // 050 MovRC r8
00000810 00000020  // 058 AddRC r8, wraps to 0x10
00020811           // 060 AddRR r8, r2
00080006 00000210  // 064 MovdCR [0x210], r8
00000812 00000913  // 06C IncR r8, 070 DecR r9 wraps to all ones
00020914 00000010  // 074 MulAddRRC r9, r2, 0x10
00080006 00000214  // 07C MovdCR [0x214], r8
00090006 00000218  // 084 MovdCR [0x218], r9
00000208 00000908  // 08C PushR r2, 090 PushR r9
00000A09 00000B09  // 094 PopR r10, 098 PopR r11
000A0006 0000021C  // 09C MovdCR [0x21C], r10
000B0006 00000220  // 0A4 MovdCR [0x220], r11
00000006 00000224  // 0AC MovdCR [0x224], r0
00000C01 00000110  // 0B4 MovRC r12, subroutine
00000C0A           // 0BC CallR r12
000D0006 00000228  // 0C0 MovdCR [0x228], r13 after return
000B020C           // 0C8 CmpRR r2, r11, equal
0000000F 00000108  // 0CC JneC, not taken
00010006 00000230  // 0D4 MovdCR [0x230], r1
0000020D 20000000  // 0DC CmpRC r2, less
0000000F 000000F4  // 0E4 JneC, taken
00020006 00000234  // 0EC MovdCR [0x234], r2 skipped
00010006 00000238  // 0F4 MovdCR [0x238], r1
0002090C           // 0FC CmpRR r9, r2, greater
00010006 0000023C  // 100 MovdCR [0x23C], r1
0000000E 00000108  // 108 JmpC to itself, halt
00000D01 5A5A5A5A  // 110 MovRC r13
000D0006 0000022C  // 118 MovdCR [0x22C], r13
0000000B           // 120 Ret
@60
CAFE0001 CAFE0002 CAFE0003
@BF
00000012
@C0
00000200 12345678  00000204 CAFE0001
00000208 CAFE0002  0000020C CAFE0003
00000210 12345688  00000214 12345689
00000218 2345677F  00000280 12345678
00000284 2345677F  0000021C 2345677F
00000220 12345678  00000224 00000280
00000280 000000BC  0000022C 5A5A5A5A
00000228 5A5A5A5A  00000230 00000001
00000238 00000002  0000023C 00000004

/* tb.f */
+incdir+include
hdl/cpuPkg.sv
hdl/regFile.sv
hdl/intExecute.sv
hdl/cpuSequencer.sv
hdl/cpuTop.sv
verif/tbCpu.sv

/* Bender.yml */
package:
  name: cpu_core

sources:
  - include_dirs:
      - include
    files:
      - hdl/cpuPkg.sv
      - hdl/regFile.sv
      - hdl/intExecute.sv
      - hdl/cpuSequencer.sv
      - hdl/cpuTop.sv
  - target: test
    include_dirs:
      - include
    files:
      - verif/tbCpu.sv

/* verif/tbCpu.sv */
`timescale 1ns/1ps
`include "cpu_consts.svh"

module tbCpu import cpuPkg::*; ();

  localparam int clkPeriod = 100;
  localparam int driveDelay = 1;
  localparam int memWords = 256;
  // Program part of the image, 0x124 bytes
  localparam int progWords = 73;
  localparam int maxDelay = 4;
  // Table layout inside the image
  localparam int countWord = 'hBF;
  localparam int tableWord = 'hC0;
  // Final JmpC of the test program
  localparam int haltAddr = 'h108;

  logic        clk;
  logic        reset;
  dataWord_t   ramIn;
  logic        readAck;
  logic        writeAck;
  dataWord_t   ramAddress;
  dataWord_t   ramOut;
  logic        readReq;
  logic        writeReq;
  dataWord_t   ipointer;
  opCode_t     opCode;

  // Memory model contents
  dataWord_t   mem [memWords];
  // Expected writes, in program order
  dataWord_t   expAddr [$];
  dataWord_t   expData [$];
  int unsigned expCount;
  int unsigned writeCount;

  cpuTop UUT (
    .clk, .reset, .ramIn, .readAck, .writeAck,
    .ramAddress, .ramOut, .readReq, .writeReq, .ipointer, .opCode
  );

  always #(clkPeriod / 2) clk = ~clk;

  // Report, mark the run as failed and stop
  task automatic abortRun(input string what);
    $display("%s", what);
    $display("TEST FAILED");
    $fatal(1, "Simulation stopped on the first error");
  endtask

  // Pull count and address/data pairs out of the image
  task automatic loadExpected();
    expCount = mem[countWord];
    for (int i = 0; i < expCount; i++)
    begin
      expAddr.push_back(mem[tableWord + 2 * i]);
      expData.push_back(mem[tableWord + 2 * i + 1]);
    end
  endtask

  // Compare one write against the next table entry
  task automatic checkWrite();
    assert (writeCount < expCount)
    else
      abortRun($sformatf("More memory writes than expected, extra write to 0x%h",
        ramAddress));
    assert (ramAddress === expAddr[writeCount])
    else
      abortRun($sformatf("Error ramAddress: write %0d expected 0x%h, got 0x%h",
        writeCount, expAddr[writeCount], ramAddress));
    assert (ramOut === expData[writeCount])
    else
      abortRun($sformatf("Error ramOut: write %0d expected 0x%h, got 0x%h",
        writeCount, expData[writeCount], ramOut));
    writeCount++;
  endtask

  // One request, one acknowledge after 1 to 4 cycles
  task automatic serveRequest();
    logic        isWrite;
    int          index;
    int unsigned delay;
    isWrite = writeReq;
    index   = ramAddress[9:2];
    delay   = ($urandom % maxDelay) + 1;
    assert (ramAddress < memWords * 4)
    else
      abortRun($sformatf("Access outside the memory model at address 0x%h", ramAddress));
    if (isWrite)
    begin
      checkWrite();
      mem[index] = ramOut;
    end
    repeat (delay) @(posedge clk);
    #driveDelay;
    // Read data travels with the acknowledge
    if (!isWrite)
      ramIn = mem[index];
    readAck  = !isWrite;
    writeAck = isWrite;
    @(posedge clk);
    #driveDelay;
    readAck  = 1'b0;
    writeAck = 1'b0;
  endtask

  // Clock, inputs and reset
  initial
  begin
    clk        = 1'b0;
    reset      = 1'b1;
    ramIn      = '0;
    readAck    = 1'b0;
    writeAck   = 1'b0;
    writeCount = 0;
    $readmemh("verif/cpu_testdata.hex", mem);
    loadExpected();
    repeat (3) @(posedge clk);
    #driveDelay;
    reset = 1'b0;
  end

  // Memory model, requests sampled mid-cycle
  initial
  begin
    // Acknowledge delays are drawn in this process
    void'($urandom(80935));
    forever
    begin
      @(negedge clk);
      if (!reset && (readReq || writeReq))
        serveRequest();
    end
  end

  // Halt detection
  initial
  begin : haltWatch
    dataWord_t lastFetch;
    logic      haltSeen;
    lastFetch = '1;
    haltSeen  = 1'b0;
    while (!haltSeen)
    begin
      @(negedge clk);
      // Instruction fetch, address equals the instruction pointer
      if (!reset && readReq && ramAddress == ipointer)
      begin
        // Same address twice in a row means a jump to itself
        haltSeen  = (ramAddress == lastFetch);
        lastFetch = ramAddress;
      end
    end
    // Last executed instruction is the jump to itself
    assert (opCode === `JmpC)
    else
      abortRun($sformatf("Error opCode: at halt expected 0x%h, got 0x%h",
        `JmpC, opCode));
    assert (ipointer === haltAddr)
    else
      abortRun($sformatf("Error ipointer: at halt expected 0x%h, got 0x%h",
        haltAddr, ipointer));
    if (writeCount == expCount)
    begin
      $display("TEST OK");
      $finish;
    end
    else
    begin
      abortRun($sformatf("Program halted after %0d of %0d expected memory writes",
        writeCount, expCount));
    end
  end

  // Watchdog sized for the worst acknowledge delay
  initial
  begin
    #(progWords * 40 * maxDelay * clkPeriod);
    abortRun("Watchdog timeout before the program reached its halt loop");
  end

endmodule

/* hdl/cpuTop.sv */
`timescale 1ns/1ps

module cpuTop import cpuPkg::*; (
  input  logic      clk,
  input  logic      reset,
  // Memory side
  input  dataWord_t ramIn,
  input  logic      readAck,
  input  logic      writeAck,
  output dataWord_t ramAddress,
  output dataWord_t ramOut,
  output logic      readReq,
  output logic      writeReq,
  // Observation
  output dataWord_t ipointer,
  output opCode_t   opCode
);

  // Register file reads
  regIdx_t   rdIdx0;
  regIdx_t   rdIdx1;
  dataWord_t rdData0;
  dataWord_t rdData1;
  dataWord_t stackPtr;
  dataWord_t flagsWord;

  // Latched instruction state
  regIdx_t   dstIdx;
  dataWord_t srcA;
  dataWord_t srcB;
  dataWord_t constWord;
  dataWord_t loadWord;
  logic      commit;
  logic      condTaken;

  // Writeback results
  regIdx_t   wrIdx;
  dataWord_t wrData;
  logic      wrEn;
  dataWord_t spData;
  logic      spEn;
  dataWord_t flagsData;
  logic      flagsEn;
  dataWord_t nextIp;

  cpuSequencer sequencer (
    .clk, .reset, .ramIn, .readAck, .writeAck,
    .rdData0, .rdData1, .flagsWord, .stackPtr, .nextIp,
    .ramAddress, .ramOut, .readReq, .writeReq, .ipointer, .opCode,
    .rdIdx0, .rdIdx1, .dstIdx, .srcA, .srcB, .constWord, .loadWord,
    .commit, .condTaken
  );

  regFile registers (
    .clk, .reset, .rdIdx0, .rdIdx1, .wrIdx, .wrData, .wrEn,
    .spData, .spEn, .flagsData, .flagsEn,
    .rdData0, .rdData1, .stackPtr, .flagsWord
  );

  intExecute execute (
    .opCode, .srcA, .srcB, .constWord, .loadWord, .stackPtr, .ipointer,
    .dstIdx, .commit, .condTaken,
    .wrIdx, .wrData, .wrEn, .spData, .spEn, .flagsData, .flagsEn, .nextIp
  );

endmodule

/* hdl/cpuSequencer.sv */
`timescale 1ns/1ps
`include "cpu_consts.svh"

module cpuSequencer import cpuPkg::*; (
  input  logic      clk,
  input  logic      reset,
  // Memory answers
  input  dataWord_t ramIn,
  input  logic      readAck,
  input  logic      writeAck,
  // Register file
  input  dataWord_t rdData0,
  input  dataWord_t rdData1,
  input  dataWord_t flagsWord,
  input  dataWord_t stackPtr,
  // From the execute block
  input  dataWord_t nextIp,
  // Memory requests
  output dataWord_t ramAddress,
  output dataWord_t ramOut,
  output logic      readReq,
  output logic      writeReq,
  output dataWord_t ipointer,
  output opCode_t   opCode,
  output regIdx_t   rdIdx0,
  output regIdx_t   rdIdx1,
  // Operands for writeback
  output regIdx_t   dstIdx,
  output dataWord_t srcA,
  output dataWord_t srcB,
  output dataWord_t constWord,
  output dataWord_t loadWord,
  output logic      commit,
  output logic      condTaken
);

  seqState_t  state;
  // Second and third register fields of the instruction word
  regIdx_t    fieldB;
  regIdx_t    fieldC;
  flagsWord_u flagsView;
  logic       isLong;
  logic       isMem;
  logic       isStore;
  dataWord_t  dataAddr;
  dataWord_t  storeData;

  // Instruction class
  assign isLong  = `IS_LONG_OP(opCode);
  assign isMem   = `IS_MEM_OP(opCode);
  assign isStore = (opCode == `MovdCR) || (opCode == `MovdRoR) ||
                   (opCode == `PushR) || (opCode == `CallR);

  // Port 0 always reads the destination field
  assign rdIdx0 = dstIdx;
  // MovdRoR takes its store data from the third field
  assign rdIdx1 = (opCode == `MovdRoR) ? fieldC : fieldB;

  assign flagsView = flagsWord;

  // Writeback lasts exactly one cycle
  assign commit = (state == Writeback);

  // Data address per memory instruction
  always_comb
  begin
    case (opCode)
      `MovRdC, `MovdCR: dataAddr = constWord;
      `MovRdRo:         dataAddr = constWord + srcB;
      `MovdRoR:         dataAddr = constWord + srcA;
      `MovRdR:          dataAddr = srcB;
      `PushR, `CallR:   dataAddr = stackPtr;
      // Top of stack sits one step below the pointer
      `PopR, `Ret:      dataAddr = stackPtr - `STACK_STEP;
      default:          dataAddr = constWord;
    endcase
  end

  // Store data
  always_comb
  begin
    case (opCode)
      `PushR:  storeData = srcA;
      // Return address is the call itself, Ret adds 4
      `CallR:  storeData = ipointer;
      default: storeData = srcB;
    endcase
  end

  // Control state
  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      state     <= Fetch;
      ipointer  <= `RESET_IP;
      opCode    <= `RESET_OPCODE;
      readReq   <= 1'b0;
      writeReq  <= 1'b0;
      condTaken <= 1'b0;
    end
    else
    begin
      // Requests are single-cycle pulses
      readReq  <= 1'b0;
      writeReq <= 1'b0;
      case (state)
        Fetch:
        begin
          readReq <= 1'b1;
          state   <= Decode;
        end
        Decode:
        begin
          if (readAck)
          begin
            opCode <= ramIn[`OP_W-1:0];
            state  <= ReadRegs;
          end
        end
        ReadRegs:
        begin
          // Flags are stable here, no write since last Writeback
          condTaken <= (opCode == `JneC) && !flagsView.cmp.equal;
          if (isLong)
          begin
            readReq <= 1'b1;
            state   <= FetchConst;
          end
          else if (isMem)
            state <= DataReq;
          else
            state <= Writeback;
        end
        FetchConst:
        begin
          if (readAck)
            state <= isMem ? DataReq : Writeback;
        end
        DataReq:
        begin
          readReq  <= !isStore;
          writeReq <= isStore;
          state    <= DataWait;
        end
        DataWait:
        begin
          // Wait on whichever acknowledge matches the request
          if (isStore ? writeAck : readAck)
            state <= Writeback;
        end
        Writeback:
        begin
          ipointer <= nextIp;
          state    <= Fetch;
        end
        default:
          state <= Fetch;
      endcase
    end
  end

  // Payload registers
  always_ff @(posedge clk)
  begin
    case (state)
      Fetch:
        ramAddress <= ipointer;
      Decode:
      begin
        // Register fields, one per byte above the opcode
        dstIdx <= ramIn[8 +: `REG_IDX_W];
        fieldB <= ramIn[16 +: `REG_IDX_W];
        fieldC <= ramIn[24 +: `REG_IDX_W];
      end
      ReadRegs:
      begin
        srcA       <= rdData0;
        srcB       <= rdData1;
        // Constant word follows the instruction word
        ramAddress <= ipointer + `SHORT_LEN;
      end
      FetchConst:
      begin
        if (readAck)
          constWord <= ramIn;
      end
      DataReq:
      begin
        ramAddress <= dataAddr;
        ramOut     <= storeData;
      end
      DataWait:
      begin
        if (readAck)
          loadWord <= ramIn;
      end
      default:
      begin
      end
    endcase
  end

endmodule

/* hdl/intExecute.sv */
`timescale 1ns/1ps
`include "cpu_consts.svh"

module intExecute import cpuPkg::*; (
  input  opCode_t   opCode,
  input  dataWord_t srcA,
  input  dataWord_t srcB,
  input  dataWord_t constWord,
  input  dataWord_t loadWord,
  input  dataWord_t stackPtr,
  input  dataWord_t ipointer,
  input  regIdx_t   dstIdx,
  input  logic      commit,
  // JneC outcome, registered in ReadRegs
  input  logic      condTaken,
  output regIdx_t   wrIdx,
  output dataWord_t wrData,
  output logic      wrEn,
  output dataWord_t spData,
  output logic      spEn,
  output dataWord_t flagsData,
  output logic      flagsEn,
  output dataWord_t nextIp
);

  logic       regWrite;
  logic       spWrite;
  logic       flagsWrite;
  dataWord_t  cmpRhs;
  flagsWord_u cmpFlags;

  // Destination is always the first field
  assign wrIdx = dstIdx;

  // Unsigned compare against a register or the constant
  assign cmpRhs = (opCode == `CmpRC) ? constWord : srcB;

  always_comb
  begin
    cmpFlags             = '0;
    cmpFlags.cmp.equal   = (srcA == cmpRhs);
    cmpFlags.cmp.less    = (srcA < cmpRhs);
    cmpFlags.cmp.greater = (srcA > cmpRhs);
  end

  assign flagsData = cmpFlags.raw;

  always_comb
  begin
    regWrite   = 1'b0;
    spWrite    = 1'b0;
    flagsWrite = 1'b0;
    wrData     = '0;
    spData     = stackPtr;
    // Fall through to the next instruction, unknown opcodes included
    nextIp     = ipointer + (`IS_LONG_OP(opCode) ? `LONG_LEN : `SHORT_LEN);
    case (opCode)
      `MovRC:
      begin
        regWrite = 1'b1;
        wrData   = constWord;
      end
      `MovRR:
      begin
        regWrite = 1'b1;
        wrData   = srcB;
      end
      `MovRdC, `MovRdRo, `MovRdR:
      begin
        regWrite = 1'b1;
        wrData   = loadWord;
      end
      `PushR:
      begin
        spWrite = 1'b1;
        spData  = stackPtr + `STACK_STEP;
      end
      `PopR:
      begin
        regWrite = 1'b1;
        wrData   = loadWord;
        spWrite  = 1'b1;
        spData   = stackPtr - `STACK_STEP;
      end
      `CallR:
      begin
        spWrite = 1'b1;
        spData  = stackPtr + `STACK_STEP;
        nextIp  = srcA;
      end
      `Ret:
      begin
        spWrite = 1'b1;
        spData  = stackPtr - `STACK_STEP;
        // Skip over the call instruction
        nextIp  = loadWord + `SHORT_LEN;
      end
      `CmpRR, `CmpRC:
        flagsWrite = 1'b1;
      `JmpC:
        nextIp = constWord;
      `JneC:
      begin
        if (condTaken)
          nextIp = constWord;
      end
      `AddRC:
      begin
        regWrite = 1'b1;
        wrData   = srcA + constWord;
      end
      `AddRR:
      begin
        regWrite = 1'b1;
        wrData   = srcA + srcB;
      end
      `IncR:
      begin
        regWrite = 1'b1;
        wrData   = srcA + dataWord_t'(1);
      end
      `DecR:
      begin
        regWrite = 1'b1;
        wrData   = srcA - dataWord_t'(1);
      end
      `MulAddRRC:
      begin
        regWrite = 1'b1;
        // Low 32 bits of the product only
        wrData   = srcA + srcB * constWord;
      end
      default:
      begin
      end
    endcase
  end

  // Only the single Writeback cycle may update state
  assign wrEn    = regWrite & commit;
  assign spEn    = spWrite & commit;
  assign flagsEn = flagsWrite & commit;

endmodule

/* hdl/regFile.sv */
`timescale 1ns/1ps
`include "cpu_consts.svh"

module regFile import cpuPkg::*; (
  input  logic      clk,
  input  logic      reset,
  input  regIdx_t   rdIdx0,
  input  regIdx_t   rdIdx1,
  // General write port
  input  regIdx_t   wrIdx,
  input  dataWord_t wrData,
  input  logic      wrEn,
  // Stack pointer side port
  input  dataWord_t spData,
  input  logic      spEn,
  // Flags side port
  input  dataWord_t flagsData,
  input  logic      flagsEn,
  output dataWord_t rdData0,
  output dataWord_t rdData1,
  output dataWord_t stackPtr,
  output dataWord_t flagsWord
);

  dataWord_t regs [`REG_COUNT];

  // Asynchronous reads
  assign rdData0   = regs[rdIdx0];
  assign rdData1   = regs[rdIdx1];
  // Fixed-role registers always visible
  assign stackPtr  = regs[`SP_REG];
  assign flagsWord = regs[`FLAGS_REG];

  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      for (int i = 0; i < `REG_COUNT; i++)
        regs[i] <= '0;
    end
    else
    begin
      if (wrEn)
        regs[wrIdx] <= wrData;
      if (flagsEn)
        regs[`FLAGS_REG] <= flagsData;
      // Stack update wins, e.g. PopR into r0
      if (spEn)
        regs[`SP_REG] <= spData;
    end
  end

endmodule

/* hdl/cpuPkg.sv */
`include "cpu_consts.svh"

package cpuPkg;

  // One memory or register word, also used for addresses
  typedef logic [`WORD_W-1:0] dataWord_t;

  // Direct index into the 64 registers
  typedef logic [`REG_IDX_W-1:0] regIdx_t;

  typedef logic [`OP_W-1:0] opCode_t;

  // Register 1 seen either as a plain word or as compare flags
  typedef union packed {
    dataWord_t raw;
    struct packed {
      logic [`WORD_W-4:0] unused;
      logic               greater;
      logic               less;
      // Tested by JneC
      logic               equal;
    } cmp;
  } flagsWord_u;

  // Sequencer steps, one instruction per pass
  typedef enum logic [2:0] {
    Fetch, Decode, ReadRegs, FetchConst, DataReq, DataWait, Writeback
  } seqState_t;

endpackage

/* include/cpu_consts.svh */
`ifndef CPU_CONSTS_SVH
`define CPU_CONSTS_SVH

// Datapath and register file geometry
`define WORD_W     32
`define REG_COUNT  64
`define REG_IDX_W  6
`define OP_W       8

// Opcode byte, low byte of the first instruction word
`define MovRC      8'h01
`define MovRdC     8'h02
`define MovRR      8'h03
`define MovRdRo    8'h04
`define MovRdR     8'h05
`define MovdCR     8'h06
`define MovdRoR    8'h07
`define PushR      8'h08
`define PopR       8'h09
`define CallR      8'h0A
`define Ret        8'h0B
`define CmpRR      8'h0C
`define CmpRC      8'h0D
`define JmpC       8'h0E
`define JneC       8'h0F
`define AddRC      8'h10
`define AddRR      8'h11
`define IncR       8'h12
`define DecR       8'h13
`define MulAddRRC  8'h14

// Byte steps for the stack and the instruction pointer
`define STACK_STEP 32'd4
`define SHORT_LEN  32'd4
`define LONG_LEN   32'd8

// Registers with a fixed role
`define SP_REG     6'd0
`define FLAGS_REG  6'd1

// Values after reset
`define RESET_IP     32'h0000_0000
`define RESET_OPCODE 8'h00

// Instructions carrying a constant in a second word
`define IS_LONG_OP(op) ((op) == `MovRC || (op) == `MovRdC || (op) == `MovRdRo || \
  (op) == `MovdCR || (op) == `MovdRoR || (op) == `CmpRC || (op) == `JmpC || \
  (op) == `JneC || (op) == `AddRC || (op) == `MulAddRRC)

// Instructions with a data read or write
`define IS_MEM_OP(op) ((op) == `MovRdC || (op) == `MovRdRo || (op) == `MovRdR || \
  (op) == `MovdCR || (op) == `MovdRoR || (op) == `PushR || (op) == `PopR || \
  (op) == `CallR || (op) == `Ret)

`endif
